// File: rtl/axil_mem_port.sv
// AXI4-Lite to memory request port
`timescale 1ns/10ps

module axil_mem_port
  import dbg_bus_pkg::*;
(
  input  logic     clk,
  input  logic     arst_n_i,
  input  axil_aw_t aw_i,
  input  logic     aw_valid_i,
  output logic     aw_ready_o,
  input  axil_w_t  w_i,
  input  logic     w_valid_i,
  output logic     w_ready_o,
  output axil_b_t  b_o,
  output logic     b_valid_o,
  input  logic     b_ready_i,
  input  axil_ar_t ar_i,
  input  logic     ar_valid_i,
  output logic     ar_ready_o,
  output axil_r_t  r_o,
  output logic     r_valid_o,
  input  logic     r_ready_i,
  output mem_req_t req_o,
  output logic     req_valid_o,
  input  logic     gnt_i,
  input  mem_rsp_t rsp_i,
  input  logic     rsp_valid_i
);

  typedef enum logic [1:0] {AX_IDLE, AX_REQ, AX_WAIT, AX_RESP} ax_state_e;

  ax_state_e   state_q;
  logic        is_wr_q;
  logic [1:0]  resp_q;
  logic [31:0] rdata_q;
  mem_req_t    req_q;
  logic        wr_go;
  logic        rd_go;

  // Write needs AW and W together and takes precedence over AR
  assign wr_go      = (state_q == AX_IDLE) & aw_valid_i & w_valid_i;
  assign rd_go      = (state_q == AX_IDLE) & ar_valid_i & ~wr_go;
  assign aw_ready_o = wr_go;
  assign w_ready_o  = wr_go;
  assign ar_ready_o = rd_go;

  assign req_o       = req_q;
  assign req_valid_o = state_q == AX_REQ;
  assign b_valid_o   = (state_q == AX_RESP) & is_wr_q;
  assign r_valid_o   = (state_q == AX_RESP) & ~is_wr_q;
  assign b_o         = '{resp: resp_q};
  assign r_o         = '{data: rdata_q, resp: resp_q};

  always_ff @(posedge clk) begin
    if (wr_go) req_q <= '{addr: aw_i.addr[31:2], we: 1'b1, wdata: w_i.data, be: w_i.strb};
    else if (rd_go) req_q <= '{addr: ar_i.addr[31:2], we: 1'b0, wdata: '0, be: '0};
    if (state_q == AX_WAIT && rsp_valid_i) rdata_q <= rsp_i.rdata;
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= AX_IDLE;
      is_wr_q <= 1'b0;
      resp_q  <= AXIL_OKAY;
    end else begin
      case (state_q)
        AX_IDLE: begin
          if (wr_go || rd_go) begin
            is_wr_q <= wr_go;
            state_q <= AX_REQ;
          end
        end
        AX_REQ: if (gnt_i) state_q <= AX_WAIT;
        AX_WAIT: begin
          if (rsp_valid_i) begin
            resp_q  <= rsp_i.err ? AXIL_SLVERR : AXIL_OKAY;
            state_q <= AX_RESP;
          end
        end
        default: if (is_wr_q ? b_ready_i : r_ready_i) state_q <= AX_IDLE;
      endcase
    end
  end

endmodule

// File: rtl/dbg_bus_pkg.sv
// Memory and AXI4-Lite bus types
package dbg_bus_pkg;

  `include "dbg_params.svh"

  // Word-addressed memory request
  typedef struct packed {
    logic [`DBG_ADDR_W-3:0]   addr;
    logic                     we;
    logic [`DBG_DATA_W-1:0]   wdata;
    logic [`DBG_DATA_W/8-1:0] be;
  } mem_req_t;

  typedef struct packed {
    logic [`DBG_DATA_W-1:0] rdata;
    logic                   err;
  } mem_rsp_t;

  // AXI4-Lite response codes
  localparam logic [1:0] AXIL_OKAY   = 2'b00;
  localparam logic [1:0] AXIL_SLVERR = 2'b10;

  typedef struct packed {
    logic [`DBG_ADDR_W-1:0] addr;
  } axil_aw_t;

  typedef struct packed {
    logic [`DBG_DATA_W-1:0]   data;
    logic [`DBG_DATA_W/8-1:0] strb;
  } axil_w_t;

  typedef struct packed {
    logic [`DBG_ADDR_W-1:0] addr;
  } axil_ar_t;

  typedef struct packed {
    logic [1:0] resp;
  } axil_b_t;

  typedef struct packed {
    logic [`DBG_DATA_W-1:0] data;
    logic [1:0]             resp;
  } axil_r_t;

endpackage

// File: rtl/dbg_params.svh
// Debug subsystem parameters
`ifndef DBG_PARAMS_SVH
`define DBG_PARAMS_SVH

// Data and address widths
`define DBG_DATA_W 32
`define DBG_ADDR_W 32

// Word SRAM, byte addresses 0x0000 to 0x0FFF
`define DBG_MEM_WORDS 1024
`define DBG_MEM_AW 10

// Scratch registers above the SRAM
`define DBG_SCRATCH0_ADDR 32'h0000_1000
`define DBG_SCRATCH1_ADDR 32'h0000_1004
`define DBG_SCRATCH2_ADDR 32'h0000_1008

// UART bit time in clock cycles
`define DBG_CLKS_PER_BIT 16

`endif

// File: rtl/dbg_proto_pkg.sv
// UART debug protocol types
package dbg_proto_pkg;

  // Command and reply byte codes
  typedef enum logic [7:0] {
    CMD_EOT   = 8'h04,
    CMD_ACK   = 8'h06,
    CMD_READ  = 8'h11,
    CMD_WRITE = 8'h12,
    CMD_EXEC  = 8'h13,
    CMD_EOC   = 8'h14
  } dbg_cmd_e;

  typedef enum logic [2:0] {
    ST_IDLE, ST_ADDR, ST_LEN, ST_DATA,
    ST_MEM_REQ, ST_MEM_WAIT, ST_SEND, ST_EOC_DATA
  } dbg_state_e;

endpackage

// File: rtl/debug_mem.sv
// Debug SRAM and scratch registers
`timescale 1ns/10ps
`include "dbg_params.svh"

module debug_mem
  import dbg_bus_pkg::*;
(
  input  logic                   clk,
  input  logic                   arst_n_i,
  input  mem_req_t               req_i,
  input  logic                   req_valid_i,
  output mem_rsp_t               rsp_o,
  output logic                   eoc_o,
  output logic [`DBG_DATA_W-1:0] eoc_code_o
);

  localparam logic [`DBG_ADDR_W-1:0] SCR0 = `DBG_SCRATCH0_ADDR;
  localparam logic [`DBG_ADDR_W-1:0] SCR1 = `DBG_SCRATCH1_ADDR;
  localparam logic [`DBG_ADDR_W-1:0] SCR2 = `DBG_SCRATCH2_ADDR;

  logic [`DBG_DATA_W-1:0] mem [`DBG_MEM_WORDS];
  logic [`DBG_ADDR_W-1:0] byte_addr;
  logic [`DBG_MEM_AW-1:0] idx;
  logic                   hit_sram, hit_s0, hit_s1, hit_s2, wr_en;
  logic [`DBG_DATA_W-1:0] s0_q, s1_q, s2_q, s2_next;
  logic [`DBG_DATA_W-1:0] sram_rd_q, scr_rd_q;
  logic                   sram_sel_q, err_q;

  function automatic logic [`DBG_DATA_W-1:0] merge_be(input logic [`DBG_DATA_W-1:0] old_w,
                                                      input logic [`DBG_DATA_W-1:0] new_w,
                                                      input logic [`DBG_DATA_W/8-1:0] be);
    logic [`DBG_DATA_W-1:0] res;
    res = old_w;
    for (int i = 0; i < `DBG_DATA_W/8; i++) begin
      if (be[i]) res[8*i +: 8] = new_w[8*i +: 8];
    end
    return res;
  endfunction

  assign byte_addr = {req_i.addr, 2'b00};
  assign idx       = req_i.addr[`DBG_MEM_AW-1:0];
  assign hit_sram  = byte_addr < `DBG_MEM_WORDS * 4;
  assign hit_s0    = byte_addr == SCR0;
  assign hit_s1    = byte_addr == SCR1;
  assign hit_s2    = byte_addr == SCR2;
  assign wr_en     = req_valid_i & req_i.we;
  assign s2_next   = merge_be(s2_q, req_i.wdata, req_i.be);

  // Unmapped addresses read as zero
  always_comb begin
    rsp_o.err   = err_q;
    rsp_o.rdata = err_q ? '0 : (sram_sel_q ? sram_rd_q : scr_rd_q);
  end

  initial begin
    for (int i = 0; i < `DBG_MEM_WORDS; i++) mem[i] = '0;
  end

  always @(posedge clk) begin
    if (req_valid_i && hit_sram) begin
      if (req_i.we) mem[idx] <= merge_be(mem[idx], req_i.wdata, req_i.be);
      sram_rd_q <= mem[idx];
    end
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      s0_q       <= '0;
      s1_q       <= '0;
      s2_q       <= '0;
      scr_rd_q   <= '0;
      sram_sel_q <= 1'b0;
      err_q      <= 1'b0;
      eoc_o      <= 1'b0;
      eoc_code_o <= '0;
    end else begin
      eoc_o <= wr_en & hit_s2 & s2_next[0];
      if (req_valid_i) begin
        sram_sel_q <= hit_sram;
        err_q      <= ~(hit_sram | hit_s0 | hit_s1 | hit_s2);
        scr_rd_q   <= hit_s0 ? s0_q : (hit_s1 ? s1_q : s2_q);
      end
      if (wr_en && hit_s0) s0_q <= merge_be(s0_q, req_i.wdata, req_i.be);
      if (wr_en && hit_s1) s1_q <= merge_be(s1_q, req_i.wdata, req_i.be);
      if (wr_en && hit_s2) begin
        s2_q <= s2_next;
        if (s2_next[0]) eoc_code_o <= s2_next;
      end
    end
  end

endmodule

// File: rtl/mem_arbiter.sv
// Two-way round-robin memory arbiter
`timescale 1ns/10ps

module mem_arbiter
  import dbg_bus_pkg::*;
(
  input  logic     clk,
  input  logic     arst_n_i,
  input  mem_req_t dbg_req_i,
  input  logic     dbg_req_valid_i,
  output logic     dbg_gnt_o,
  output mem_rsp_t dbg_rsp_o,
  output logic     dbg_rsp_valid_o,
  input  mem_req_t bus_req_i,
  input  logic     bus_req_valid_i,
  output logic     bus_gnt_o,
  output mem_rsp_t bus_rsp_o,
  output logic     bus_rsp_valid_o,
  output mem_req_t mem_req_o,
  output logic     mem_req_valid_o,
  input  mem_rsp_t mem_rsp_i
);

  // Set when the bus side wins the next tie
  logic prio_bus_q;
  logic pick_bus;
  logic gnt_q;
  logic gnt_bus_q;

  assign pick_bus        = bus_req_valid_i & (~dbg_req_valid_i | prio_bus_q);
  assign mem_req_valid_o = dbg_req_valid_i | bus_req_valid_i;
  assign mem_req_o       = pick_bus ? bus_req_i : dbg_req_i;
  assign dbg_gnt_o       = dbg_req_valid_i & ~pick_bus;
  assign bus_gnt_o       = pick_bus;

  // Response comes one cycle after the grant
  assign dbg_rsp_o       = mem_rsp_i;
  assign bus_rsp_o       = mem_rsp_i;
  assign dbg_rsp_valid_o = gnt_q & ~gnt_bus_q;
  assign bus_rsp_valid_o = gnt_q & gnt_bus_q;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      prio_bus_q <= 1'b0;
      gnt_q      <= 1'b0;
      gnt_bus_q  <= 1'b0;
    end else begin
      gnt_q     <= mem_req_valid_o;
      gnt_bus_q <= pick_bus;
      if (mem_req_valid_o) prio_bus_q <= ~pick_bus;
    end
  end

endmodule

// File: rtl/uart_debug_server.sv
// UART debug command server
`timescale 1ns/10ps
`include "dbg_params.svh"

module uart_debug_server
  import dbg_bus_pkg::*;
  import dbg_proto_pkg::*;
(
  input  logic                   clk,
  input  logic                   arst_n_i,
  input  logic [7:0]             rx_byte_i,
  input  logic                   rx_valid_i,
  output logic [7:0]             tx_byte_o,
  output logic                   tx_valid_o,
  input  logic                   tx_ready_i,
  output mem_req_t               req_o,
  output logic                   req_valid_o,
  input  logic                   gnt_i,
  input  mem_rsp_t               rsp_i,
  input  logic                   rsp_valid_i,
  input  logic                   eoc_i,
  input  logic [`DBG_DATA_W-1:0] eoc_code_i
);

  localparam logic [`DBG_ADDR_W-1:0] SCR0 = `DBG_SCRATCH0_ADDR;
  localparam logic [`DBG_ADDR_W-1:0] SCR1 = `DBG_SCRATCH1_ADDR;
  localparam logic [`DBG_ADDR_W-1:0] SCR2 = `DBG_SCRATCH2_ADDR;

  dbg_state_e             state_q;
  dbg_state_e             ret_q;
  dbg_cmd_e               cmd_q;
  logic [2:0]             cnt_q;
  logic [1:0]             step_q;
  logic [7:0]             tx_byte_q;
  logic [63:0]            addr_q;
  logic [31:0]            len_q;
  logic [7:0]             wdata_q;
  logic                   eoc_pend_q;
  logic [`DBG_DATA_W-1:0] eoc_code_q;

  assign tx_byte_o   = tx_byte_q;
  assign tx_valid_o  = state_q == ST_SEND;
  assign req_valid_o = state_q == ST_MEM_REQ;

  // Byte access for read and write, full word stores for exec
  always_comb begin
    req_o = '0;
    if (cmd_q == CMD_EXEC) begin
      req_o.we = 1'b1;
      req_o.be = '1;
      case (step_q)
        2'd0: begin
          req_o.addr  = SCR0[`DBG_ADDR_W-1:2];
          req_o.wdata = addr_q[31:0];
        end
        2'd1: begin
          req_o.addr  = SCR1[`DBG_ADDR_W-1:2];
          req_o.wdata = addr_q[63:32];
        end
        default: begin
          req_o.addr  = SCR2[`DBG_ADDR_W-1:2];
          req_o.wdata = 32'd2;
        end
      endcase
    end else begin
      req_o.addr  = addr_q[`DBG_ADDR_W-1:2];
      req_o.we    = cmd_q == CMD_WRITE;
      req_o.be    = 4'b0001 << addr_q[1:0];
      req_o.wdata = {4{wdata_q}};
    end
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q    <= ST_IDLE;
      ret_q      <= ST_IDLE;
      cmd_q      <= CMD_ACK;
      cnt_q      <= '0;
      step_q     <= '0;
      tx_byte_q  <= '0;
      addr_q     <= '0;
      len_q      <= '0;
      wdata_q    <= '0;
      eoc_pend_q <= 1'b0;
      eoc_code_q <= '0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          cnt_q  <= '0;
          step_q <= '0;
          if (eoc_pend_q) begin
            eoc_pend_q <= 1'b0;
            tx_byte_q  <= CMD_EOC;
            ret_q      <= ST_EOC_DATA;
            state_q    <= ST_SEND;
          end else if (rx_valid_i) begin
            case (rx_byte_i)
              CMD_ACK: begin
                tx_byte_q <= CMD_ACK;
                ret_q     <= ST_IDLE;
                state_q   <= ST_SEND;
              end
              CMD_READ, CMD_WRITE, CMD_EXEC: begin
                cmd_q   <= dbg_cmd_e'(rx_byte_i);
                state_q <= ST_ADDR;
              end
              default: state_q <= ST_IDLE;
            endcase
          end
        end
        ST_ADDR: begin
          if (rx_valid_i) begin
            addr_q[8*cnt_q +: 8] <= rx_byte_i;
            cnt_q                <= cnt_q + 1'b1;
            if (cnt_q == 3'd7) state_q <= (cmd_q == CMD_EXEC) ? ST_MEM_REQ : ST_LEN;
          end
        end
        ST_LEN: begin
          if (rx_valid_i) begin
            // Upper length bytes are ignored
            if (!cnt_q[2]) len_q[8*cnt_q[1:0] +: 8] <= rx_byte_i;
            cnt_q <= cnt_q + 1'b1;
            if (cnt_q == 3'd7) begin
              tx_byte_q <= CMD_ACK;
              ret_q     <= ST_DATA;
              state_q   <= ST_SEND;
            end
          end
        end
        ST_DATA: begin
          if (len_q == '0) begin
            tx_byte_q <= CMD_EOT;
            ret_q     <= ST_IDLE;
            state_q   <= ST_SEND;
          end else if (cmd_q != CMD_WRITE) begin
            state_q <= ST_MEM_REQ;
          end else if (rx_valid_i) begin
            wdata_q <= rx_byte_i;
            state_q <= ST_MEM_REQ;
          end
        end
        ST_MEM_REQ: begin
          if (gnt_i) state_q <= ST_MEM_WAIT;
        end
        ST_MEM_WAIT: begin
          if (rsp_valid_i) begin
            if (cmd_q == CMD_EXEC) begin
              step_q  <= step_q + 1'b1;
              state_q <= ST_MEM_REQ;
              if (step_q == 2'd2) begin
                tx_byte_q <= CMD_ACK;
                ret_q     <= ST_IDLE;
                state_q   <= ST_SEND;
              end
            end else begin
              addr_q[31:0] <= addr_q[31:0] + 1'b1;
              len_q        <= len_q - 1'b1;
              state_q      <= ST_DATA;
              if (cmd_q == CMD_READ) begin
                // Pick the byte lane of the current address
                tx_byte_q <= rsp_i.rdata[8*addr_q[1:0] +: 8];
                ret_q     <= ST_DATA;
                state_q   <= ST_SEND;
              end
            end
          end
        end
        ST_SEND: begin
          if (tx_ready_i) state_q <= ret_q;
        end
        ST_EOC_DATA: begin
          tx_byte_q <= eoc_code_q[8*cnt_q[1:0] +: 8];
          cnt_q     <= (cnt_q == 3'd3) ? 3'd0 : cnt_q + 1'b1;
          ret_q     <= (cnt_q == 3'd3) ? ST_IDLE : ST_EOC_DATA;
          state_q   <= ST_SEND;
        end
        default: state_q <= ST_IDLE;
      endcase
      // A new end of computation wins over the clear above
      if (eoc_i) begin
        eoc_pend_q <= 1'b1;
        eoc_code_q <= eoc_code_i;
      end
    end
  end

endmodule

// File: rtl/uart_debug_top.sv
// UART debug and AXI4-Lite memory top
`timescale 1ns/10ps
`include "dbg_params.svh"

module uart_debug_top
  import dbg_bus_pkg::*;
(
  input  logic     clk,
  input  logic     arst_n_i,
  input  logic     uart_rx_i,
  output logic     uart_tx_o,
  input  axil_aw_t aw_i,
  input  logic     aw_valid_i,
  output logic     aw_ready_o,
  input  axil_w_t  w_i,
  input  logic     w_valid_i,
  output logic     w_ready_o,
  output axil_b_t  b_o,
  output logic     b_valid_o,
  input  logic     b_ready_i,
  input  axil_ar_t ar_i,
  input  logic     ar_valid_i,
  output logic     ar_ready_o,
  output axil_r_t  r_o,
  output logic     r_valid_o,
  input  logic     r_ready_i
);

  logic [7:0]             rx_byte, tx_byte;
  logic                   rx_valid, tx_valid, tx_ready;
  mem_req_t               dbg_req, bus_req, mem_req;
  mem_rsp_t               dbg_rsp, bus_rsp, mem_rsp;
  logic                   dbg_req_valid, dbg_gnt, dbg_rsp_valid;
  logic                   bus_req_valid, bus_gnt, bus_rsp_valid;
  logic                   mem_req_valid;
  logic                   eoc;
  logic [`DBG_DATA_W-1:0] eoc_code;

  uart_phy u_phy (
    .clk, .arst_n_i, .uart_rx_i, .uart_tx_o,
    .rx_byte_o (rx_byte), .rx_valid_o (rx_valid),
    .tx_byte_i (tx_byte), .tx_valid_i (tx_valid), .tx_ready_o (tx_ready)
  );

  uart_debug_server u_server (
    .clk, .arst_n_i,
    .rx_byte_i   (rx_byte),   .rx_valid_i  (rx_valid),
    .tx_byte_o   (tx_byte),   .tx_valid_o  (tx_valid), .tx_ready_i (tx_ready),
    .req_o       (dbg_req),   .req_valid_o (dbg_req_valid), .gnt_i (dbg_gnt),
    .rsp_i       (dbg_rsp),   .rsp_valid_i (dbg_rsp_valid),
    .eoc_i       (eoc),       .eoc_code_i  (eoc_code)
  );

  axil_mem_port u_axil (
    .clk, .arst_n_i,
    .aw_i, .aw_valid_i, .aw_ready_o, .w_i, .w_valid_i, .w_ready_o,
    .b_o, .b_valid_o, .b_ready_i, .ar_i, .ar_valid_i, .ar_ready_o,
    .r_o, .r_valid_o, .r_ready_i,
    .req_o (bus_req), .req_valid_o (bus_req_valid), .gnt_i (bus_gnt),
    .rsp_i (bus_rsp), .rsp_valid_i (bus_rsp_valid)
  );

  mem_arbiter u_arb (
    .clk, .arst_n_i,
    .dbg_req_i (dbg_req), .dbg_req_valid_i (dbg_req_valid), .dbg_gnt_o (dbg_gnt),
    .dbg_rsp_o (dbg_rsp), .dbg_rsp_valid_o (dbg_rsp_valid),
    .bus_req_i (bus_req), .bus_req_valid_i (bus_req_valid), .bus_gnt_o (bus_gnt),
    .bus_rsp_o (bus_rsp), .bus_rsp_valid_o (bus_rsp_valid),
    .mem_req_o (mem_req), .mem_req_valid_o (mem_req_valid), .mem_rsp_i (mem_rsp)
  );

  debug_mem u_mem (
    .clk, .arst_n_i,
    .req_i (mem_req), .req_valid_i (mem_req_valid), .rsp_o (mem_rsp),
    .eoc_o (eoc), .eoc_code_o (eoc_code)
  );

endmodule

// File: rtl/uart_phy.sv
// UART 8N1 transceiver
`timescale 1ns/10ps
`include "dbg_params.svh"

module uart_phy (
  input  logic       clk,
  input  logic       arst_n_i,
  input  logic       uart_rx_i,
  output logic       uart_tx_o,
  output logic [7:0] rx_byte_o,
  output logic       rx_valid_o,
  input  logic [7:0] tx_byte_i,
  input  logic       tx_valid_i,
  output logic       tx_ready_o
);

  localparam int CNT_W = $clog2(`DBG_CLKS_PER_BIT);
  localparam logic [CNT_W-1:0] LAST = CNT_W'(`DBG_CLKS_PER_BIT - 1);
  localparam logic [CNT_W-1:0] HALF = CNT_W'(`DBG_CLKS_PER_BIT / 2 - 1);

  typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

  rx_state_e        rx_state_q;
  logic [1:0]       rx_sync_q;
  logic [CNT_W-1:0] rx_cnt_q;
  logic [2:0]       rx_bit_q;
  logic [7:0]       rx_shift_q;

  logic             tx_busy_q;
  logic [9:0]       tx_shift_q;
  logic [CNT_W-1:0] tx_cnt_q;
  logic [3:0]       tx_bit_q;

  assign rx_byte_o  = rx_shift_q;
  assign tx_ready_o = ~tx_busy_q;
  // Line idles high between frames
  assign uart_tx_o  = tx_busy_q ? tx_shift_q[0] : 1'b1;

  // Receiver, samples each bit at its middle
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rx_sync_q  <= 2'b11;
      rx_state_q <= RX_IDLE;
      rx_cnt_q   <= '0;
      rx_bit_q   <= '0;
      rx_shift_q <= '0;
      rx_valid_o <= 1'b0;
    end else begin
      rx_sync_q  <= {rx_sync_q[0], uart_rx_i};
      rx_valid_o <= 1'b0;
      rx_cnt_q   <= rx_cnt_q + 1'b1;
      case (rx_state_q)
        RX_IDLE: begin
          rx_cnt_q <= '0;
          if (!rx_sync_q[1]) rx_state_q <= RX_START;
        end
        RX_START: begin
          if (rx_cnt_q == HALF) begin
            rx_cnt_q   <= '0;
            rx_bit_q   <= '0;
            // A glitch shorter than half a bit is dropped
            rx_state_q <= rx_sync_q[1] ? RX_IDLE : RX_DATA;
          end
        end
        RX_DATA: begin
          if (rx_cnt_q == LAST) begin
            rx_shift_q <= {rx_sync_q[1], rx_shift_q[7:1]};
            rx_bit_q   <= rx_bit_q + 1'b1;
            if (rx_bit_q == 3'd7) rx_state_q <= RX_STOP;
          end
        end
        default: begin
          if (rx_cnt_q == LAST) begin
            rx_valid_o <= rx_sync_q[1];
            rx_state_q <= RX_IDLE;
          end
        end
      endcase
    end
  end

  // Transmitter, shifts out start, data and stop bits
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      tx_busy_q  <= 1'b0;
      tx_shift_q <= '1;
      tx_cnt_q   <= '0;
      tx_bit_q   <= '0;
    end else if (!tx_busy_q) begin
      if (tx_valid_i) begin
        tx_busy_q  <= 1'b1;
        tx_shift_q <= {1'b1, tx_byte_i, 1'b0};
        tx_cnt_q   <= '0;
        tx_bit_q   <= '0;
      end
    end else begin
      tx_cnt_q <= tx_cnt_q + 1'b1;
      if (tx_cnt_q == LAST) begin
        tx_cnt_q   <= '0;
        tx_bit_q   <= tx_bit_q + 1'b1;
        tx_shift_q <= {1'b1, tx_shift_q[9:1]};
        if (tx_bit_q == 4'd9) tx_busy_q <= 1'b0;
      end
    end
  end

endmodule

// File: verification/tb_uart_debug_tasks.svh
// UART, AXI4-Lite and random stimulus helpers

// Drive one 8N1 frame on the UART line, LSB first
task automatic send_byte(input logic [7:0] b);
  logic [9:0] frame;
  frame = {1'b1, b, 1'b0};
  for (int i = 0; i < 10; i++) begin
    @(negedge clk);
    uart_rx = frame[i];
    repeat (BIT - 1) @(negedge clk);
  end
endtask

// Command byte, then 8 address bytes and 8 length bytes, LSB first
task automatic uart_cmd(input logic [7:0] cmd, input logic [63:0] addr, input logic [63:0] len);
  send_byte(cmd);
  for (int i = 0; i < 8; i++) send_byte(addr[8*i +: 8]);
  for (int i = 0; i < 8; i++) send_byte(len[8*i +: 8]);
endtask

task automatic pop_rx_byte(output logic [7:0] b);
  int n;
  n = 0;
  while (rx_q.size() == 0) begin
    @(negedge clk);
    n++;
    if (n > BYTE_TIMEOUT) fail_stop("Timeout waiting for a byte from the UART");
  end
  b = rx_q.pop_front();
endtask

task automatic expect_rx(input logic [7:0] exp);
  logic [7:0] got;
  pop_rx_byte(got);
  check_value("uart_tx_o byte", got, exp);
endtask

task automatic axil_write(input logic [31:0] addr, input logic [31:0] data,
                          output logic [1:0] resp);
  int n;
  @(negedge clk);
  aw.addr  = addr;
  w.data   = data;
  w.strb   = 4'hF;
  aw_valid = 1'b1;
  w_valid  = 1'b1;
  n = 0;
  #1;
  while (!(aw_ready && w_ready)) begin
    @(negedge clk);
    #1;
    n++;
    if (n > AXI_TIMEOUT) fail_stop("Timeout waiting for the AXI write to be accepted");
  end
  @(negedge clk);
  aw_valid = 1'b0;
  w_valid  = 1'b0;
  b_ready  = 1'b1;
  n = 0;
  while (!b_valid) begin
    @(negedge clk);
    n++;
    if (n > AXI_TIMEOUT) fail_stop("Timeout waiting for the AXI write response");
  end
  resp = b.resp;
  @(negedge clk);
  b_ready = 1'b0;
endtask

task automatic axil_read(input logic [31:0] addr, output logic [31:0] data,
                         output logic [1:0] resp);
  int n;
  @(negedge clk);
  ar.addr  = addr;
  ar_valid = 1'b1;
  n = 0;
  #1;
  while (!ar_ready) begin
    @(negedge clk);
    #1;
    n++;
    if (n > AXI_TIMEOUT) fail_stop("Timeout waiting for the AXI read to be accepted");
  end
  @(negedge clk);
  ar_valid = 1'b0;
  r_ready  = 1'b1;
  n = 0;
  while (!r_valid) begin
    @(negedge clk);
    n++;
    if (n > AXI_TIMEOUT) fail_stop("Timeout waiting for the AXI read data");
  end
  data = r.data;
  resp = r.resp;
  @(negedge clk);
  r_ready = 1'b0;
endtask

// Galois LFSR, x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
  return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
endfunction

// One LFSR step per bit taken
function automatic logic [31:0] rand_bits(input int n);
  logic [31:0] v;
  v = '0;
  for (int i = 0; i < n; i++) begin
    v[i]       = lfsr_state[0];
    lfsr_state = lfsr_next(lfsr_state);
  end
  return v;
endfunction

// File: verification/tb_uart_debug.sv
// UART debug subsystem testbench
`timescale 1ns/10ps
`include "dbg_params.svh"

module tb_uart_debug
  import dbg_bus_pkg::*;
();

  localparam int BIT          = `DBG_CLKS_PER_BIT;
  localparam int AXI_TIMEOUT  = 1000;
  localparam int BYTE_TIMEOUT = 40 * 10 * BIT;

  // Protocol byte codes and AXI responses
  localparam logic [7:0] B_ACK  = 8'h06;
  localparam logic [7:0] B_EOT  = 8'h04;
  localparam logic [7:0] B_RD   = 8'h11;
  localparam logic [7:0] B_WR   = 8'h12;
  localparam logic [7:0] B_EXEC = 8'h13;
  localparam logic [7:0] B_EOC  = 8'h14;
  localparam logic [1:0] R_OKAY   = 2'b00;
  localparam logic [1:0] R_SLVERR = 2'b10;

  logic     clk;
  logic     arst_n_i;
  logic     uart_rx, uart_tx;
  axil_aw_t aw;
  axil_w_t  w;
  axil_b_t  b;
  axil_ar_t ar;
  axil_r_t  r;
  logic     aw_valid, aw_ready, w_valid, w_ready, b_valid, b_ready;
  logic     ar_valid, ar_ready, r_valid, r_ready;

  logic [7:0]  rx_q [$];
  logic [31:0] lfsr_state = 32'd9;
  logic [31:0] model_w [`DBG_MEM_WORDS];
  logic        mon_busy;
  int          mon_cnt;
  logic [7:0]  mon_shift;

  task automatic fail_stop(input string why);
    $display(">>> FAIL");
    $display("%s", why);
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp)
    else fail_stop($sformatf("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp));
  endtask

  `include "tb_uart_debug_tasks.svh"

  // Expected SRAM contents kept as words
  task automatic store_model_byte(input logic [31:0] addr, input logic [7:0] v);
    model_w[addr[11:2]][8*addr[1:0] +: 8] = v;
  endtask

  function automatic logic [7:0] expected_byte(input logic [31:0] addr);
    return model_w[addr[11:2]][8*addr[1:0] +: 8];
  endfunction

  uart_debug_top UUT (
    .clk, .arst_n_i, .uart_rx_i (uart_rx), .uart_tx_o (uart_tx),
    .aw_i (aw), .aw_valid_i (aw_valid), .aw_ready_o (aw_ready),
    .w_i (w), .w_valid_i (w_valid), .w_ready_o (w_ready),
    .b_o (b), .b_valid_o (b_valid), .b_ready_i (b_ready),
    .ar_i (ar), .ar_valid_i (ar_valid), .ar_ready_o (ar_ready),
    .r_o (r), .r_valid_o (r_valid), .r_ready_i (r_ready)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Decodes frames on uart_tx_o at the middle of each bit
  always @(negedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      mon_busy  <= 1'b0;
      mon_cnt   <= 0;
      mon_shift <= '0;
    end else if (!mon_busy) begin
      mon_cnt <= 1;
      if (!uart_tx) mon_busy <= 1'b1;
    end else begin
      mon_cnt <= mon_cnt + 1;
      if (mon_cnt % BIT == BIT / 2 && mon_cnt > BIT) begin
        if (mon_cnt / BIT <= 8) begin
          mon_shift[mon_cnt / BIT - 1] <= uart_tx;
        end else begin
          mon_busy <= 1'b0;
          assert (uart_tx === 1'b1) else fail_stop("UART frame ended with a low stop bit");
          rx_q.push_back(mon_shift);
        end
      end
    end
  end

  initial begin
    logic [31:0] rd_data;
    logic [31:0] wd;
    logic [1:0]  resp;
    logic [63:0] entry;
    logic        rd_done;
    uart_rx  = 1'b1;
    aw       = '0;
    w        = '0;
    ar       = '0;
    aw_valid = 1'b0;
    w_valid  = 1'b0;
    b_ready  = 1'b0;
    ar_valid = 1'b0;
    r_ready  = 1'b0;
    arst_n_i = 1'b0;
    for (int i = 0; i < `DBG_MEM_WORDS; i++) model_w[i] = '0;
    repeat (2) @(negedge clk);
    arst_n_i = 1'b1;

    // Quiet outputs after reset, then the ACK challenge
    for (int i = 0; i < 4 * BIT; i++) begin
      @(negedge clk);
      check_value("uart_tx_o", uart_tx, 1'b1);
      check_value("b_valid_o", b_valid, 1'b0);
      check_value("r_valid_o", r_valid, 1'b0);
    end
    send_byte(B_ACK);
    expect_rx(B_ACK);

    // UART write of 12 bytes, read back over AXI
    uart_cmd(B_WR, 64'h20, 64'd12);
    for (int i = 0; i < 12; i++) begin
      wd = rand_bits(8);
      store_model_byte(32'h20 + i, wd[7:0]);
      send_byte(wd[7:0]);
    end
    expect_rx(B_ACK);
    expect_rx(B_EOT);
    for (int i = 0; i < 3; i++) begin
      axil_read(32'h20 + 4 * i, rd_data, resp);
      check_value("r_o.data", rd_data, model_w[8 + i]);
      check_value("r_o.resp", resp, R_OKAY);
    end

    // Fill 0x40 over AXI so the UART read has data to return
    for (int i = 0; i < 4; i++) begin
      wd = rand_bits(32);
      model_w[16 + i] = wd;
      axil_write(32'h40 + 4 * i, wd, resp);
      check_value("b_o.resp", resp, R_OKAY);
    end

    // UART read while a stream of AXI writes competes for the memory
    rd_done = 1'b0;
    fork
      begin
        uart_cmd(B_RD, 64'h40, 64'd16);
        expect_rx(B_ACK);
        for (int i = 0; i < 16; i++) expect_rx(expected_byte(32'h40 + i));
        expect_rx(B_EOT);
        rd_done = 1'b1;
      end
      begin
        logic [31:0] bus_wd;
        logic [1:0]  bus_resp;
        int          k;
        k = 0;
        // Short random gaps move the write phase against the server requests
        while (!rd_done) begin
          repeat (rand_bits(2)) @(negedge clk);
          bus_wd = rand_bits(32);
          model_w[64 + k % 4] = bus_wd;
          axil_write(32'h100 + 4 * (k % 4), bus_wd, bus_resp);
          check_value("b_o.resp", bus_resp, R_OKAY);
          k++;
        end
      end
    join
    uart_cmd(B_RD, 64'h100, 64'd16);
    expect_rx(B_ACK);
    for (int i = 0; i < 16; i++) expect_rx(expected_byte(32'h100 + i));
    expect_rx(B_EOT);

    // Exec fills the three scratch registers
    entry = 64'h0000_0001_0000_0080;
    send_byte(B_EXEC);
    for (int i = 0; i < 8; i++) send_byte(entry[8*i +: 8]);
    expect_rx(B_ACK);
    axil_read(`DBG_SCRATCH0_ADDR, rd_data, resp);
    check_value("r_o.data", rd_data, 32'h0000_0080);
    axil_read(`DBG_SCRATCH1_ADDR, rd_data, resp);
    check_value("r_o.data", rd_data, 32'h0000_0001);
    axil_read(`DBG_SCRATCH2_ADDR, rd_data, resp);
    check_value("r_o.data", rd_data, 32'h0000_0002);

    // End of computation reported over the UART
    wd = (rand_bits(16) << 1) | 32'd1;
    axil_write(`DBG_SCRATCH2_ADDR, wd, resp);
    check_value("b_o.resp", resp, R_OKAY);
    expect_rx(B_EOC);
    for (int i = 0; i < 4; i++) expect_rx(wd[8*i +: 8]);

    // Unmapped address gives SLVERR and zero data
    axil_read(32'h2000, rd_data, resp);
    check_value("r_o.resp", resp, R_SLVERR);
    check_value("r_o.data", rd_data, 32'h0);
    axil_write(32'h2000, rand_bits(32), resp);
    check_value("b_o.resp", resp, R_SLVERR);
    axil_read(32'h20, rd_data, resp);
    check_value("r_o.data", rd_data, model_w[8]);
    check_value("r_o.resp", resp, R_OKAY);

    // Nothing more may come out of the UART
    repeat (2 * 10 * BIT) @(negedge clk);
    assert (rx_q.size() == 0) else fail_stop("Unexpected extra bytes from the UART");
    $display(">>> PASS");
    $finish;
  end

endmodule

// File: vlog.f
+incdir+rtl
+incdir+verification
rtl/dbg_bus_pkg.sv
rtl/dbg_proto_pkg.sv
rtl/uart_phy.sv
rtl/uart_debug_server.sv
rtl/axil_mem_port.sv
rtl/mem_arbiter.sv
rtl/debug_mem.sv
rtl/uart_debug_top.sv
verification/tb_uart_debug.sv
